// File: hw/rv32i_macros.svh
`ifndef RV32I_MACROS_SVH
`define RV32I_MACROS_SVH

// datapath width for registers, PC and instruction words
`define RV_XLEN 32

// first PC handed out after reset
`define RV_RESET_PC 32'h0000_0000

// PC increment per accepted instruction
`define RV_PC_STEP 32'd4

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

// register index width
`define RV_REG_BITS 5

`endif

// File: hw/rv32i_pkg.sv
`default_nettype none

`include "rv32i_macros.svh"

package rv32i_pkg;

    typedef logic [`RV_XLEN-1:0] rv32i_word;

    // major opcodes handled by this core
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode_t;

    // encodings follow funct3, sub/sra come from alu_alt
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops_t;

    typedef enum logic {
        cmp_lt  = 1'b0,
        cmp_ltu = 1'b1
    } cmp_ops_t;

    typedef enum logic {
        sel_rs1 = 1'b0,
        sel_pc  = 1'b1
    } alumux1_sel_t;

    typedef enum logic {
        sel_imm = 1'b0,
        sel_rs2 = 1'b1
    } alumux2_sel_t;

    // second compare operand source
    typedef enum logic {
        cmp_sel_rs2 = 1'b0,
        cmp_sel_imm = 1'b1
    } cmpmux_sel_t;

    typedef enum logic {
        res_alu = 1'b0,
        res_cmp = 1'b1
    } result_sel_t;

endpackage

`default_nettype wire

// File: hw/fetch_stage.sv
`default_nettype none

`include "rv32i_macros.svh"

module fetch_stage
    import rv32i_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      instr_valid,
    input  rv32i_word instr,
    output logic      f_valid,
    output rv32i_word f_pc,
    output rv32i_word f_instr
);

    // next PC to hand out
    rv32i_word pc;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            f_valid <= 1'b0;
            f_pc    <= `RV_RESET_PC;
            f_instr <= `RV_NOP;
            pc      <= `RV_RESET_PC;
        end
        else
        begin
            f_valid <= instr_valid;
            // idle cycles hold the counter
            if (instr_valid)
            begin
                f_pc    <= pc;
                f_instr <= instr;
                pc      <= pc + `RV_PC_STEP;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/regfile.sv
`default_nettype none

`include "rv32i_macros.svh"

module regfile
    import rv32i_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load,
    input  rv32i_word               in,
    input  logic [`RV_REG_BITS-1:0] src_a,
    input  logic [`RV_REG_BITS-1:0] src_b,
    input  logic [`RV_REG_BITS-1:0] dest,
    output rv32i_word               reg_a,
    output rv32i_word               reg_b
);

    // x0 has no storage
    rv32i_word regs [1:31];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (load && dest != '0)
        begin
            regs[dest] <= in;
        end
    end

    // write-through so a read in the writeback cycle sees the new value
    always_comb
    begin
        if (src_a == '0)
            reg_a = '0;
        else if (load && dest == src_a)
            reg_a = in;
        else
            reg_a = regs[src_a];

        if (src_b == '0)
            reg_b = '0;
        else if (load && dest == src_b)
            reg_b = in;
        else
            reg_b = regs[src_b];
    end

endmodule

`default_nettype wire

// File: hw/control_rom.sv
`default_nettype none

module control_rom
    import rv32i_pkg::*;
(
    input  rv32i_word    data,
    output alumux1_sel_t alumux1_sel,
    output alumux2_sel_t alumux2_sel,
    output cmpmux_sel_t  cmpmux_sel,
    output alu_ops_t     alu_op,
    output logic         alu_alt,
    output cmp_ops_t     cmp_op,
    output result_sel_t  result_sel,
    output logic         reg_write,
    output logic         imm_sel
);

    rv32i_opcode_t opcode;
    logic [2:0]    funct3;
    logic          funct7_b5;

    assign opcode    = rv32i_opcode_t'(data[6:0]);
    assign funct3    = data[14:12];
    assign funct7_b5 = data[30];

    always_comb
    begin
        alumux1_sel = sel_rs1;
        alumux2_sel = sel_imm;
        cmpmux_sel  = cmp_sel_imm;
        alu_op      = alu_add;
        alu_alt     = 1'b0;
        cmp_op      = cmp_lt;
        result_sel  = res_alu;
        reg_write   = 1'b0;
        // imm_sel high picks the U immediate
        imm_sel     = 1'b0;

        case (opcode)
            op_lui:
            begin
                imm_sel   = 1'b1;
                reg_write = 1'b1;
            end
            op_auipc:
            begin
                alumux1_sel = sel_pc;
                imm_sel     = 1'b1;
                reg_write   = 1'b1;
            end
            op_imm:
            begin
                reg_write = 1'b1;
                // only srai uses bit 30, elsewhere it is immediate data
                alu_alt   = funct7_b5 && funct3 == 3'b101;
            end
            op_reg:
            begin
                alumux2_sel = sel_rs2;
                cmpmux_sel  = cmp_sel_rs2;
                reg_write   = 1'b1;
                alu_alt     = funct7_b5 && (funct3 == 3'b000 || funct3 == 3'b101);
            end
            default:
            begin
                // unsupported, retire as a no-op
                reg_write = 1'b0;
            end
        endcase

        if (opcode == op_imm || opcode == op_reg)
        begin
            case (funct3)
                3'b000: alu_op = alu_add;
                3'b001: alu_op = alu_sll;
                3'b010:
                begin
                    result_sel = res_cmp;
                    cmp_op     = cmp_lt;
                end
                3'b011:
                begin
                    result_sel = res_cmp;
                    cmp_op     = cmp_ltu;
                end
                3'b100: alu_op = alu_xor;
                3'b101: alu_op = alu_srl;
                3'b110: alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/instruction_decode.sv
`default_nettype none

`include "rv32i_macros.svh"

module instruction_decode
    import rv32i_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    f_valid,
    input  rv32i_word               f_pc,
    input  rv32i_word               f_instr,
    input  logic                    wb_load,
    input  logic [`RV_REG_BITS-1:0] wb_rd,
    input  rv32i_word               wb_data,
    output logic                    d_valid,
    output rv32i_word               d_pc,
    output rv32i_word               d_instr,
    output alu_ops_t                alu_op,
    output logic                    alu_alt,
    output cmp_ops_t                cmp_op,
    output result_sel_t             result_sel,
    output logic                    reg_write,
    output rv32i_word               d_alu_a,
    output rv32i_word               d_alu_b,
    output rv32i_word               d_cmp_a,
    output rv32i_word               d_cmp_b
);

    rv32i_word               i_imm;
    rv32i_word               u_imm;
    rv32i_word               imm;
    rv32i_word               reg_a;
    rv32i_word               reg_b;
    rv32i_word               alu_a;
    rv32i_word               alu_b;
    rv32i_word               cmp_b;
    logic [`RV_REG_BITS-1:0] rs1_addr;

    alumux1_sel_t alumux1_sel;
    alumux2_sel_t alumux2_sel;
    cmpmux_sel_t  cmpmux_sel;
    alu_ops_t     ctl_alu_op;
    logic         ctl_alu_alt;
    cmp_ops_t     ctl_cmp_op;
    result_sel_t  ctl_result_sel;
    logic         ctl_reg_write;
    logic         imm_sel;

    assign i_imm = {{21{f_instr[31]}}, f_instr[30:20]};
    assign u_imm = {f_instr[31:12], 12'h000};
    assign imm   = imm_sel ? u_imm : i_imm;

    // lui reads x0 so the adder passes the immediate through
    assign rs1_addr = (f_instr[6:0] == op_lui) ? '0 : f_instr[19:15];

    regfile u_regfile (
        .clk   (clk),
        .rst   (rst),
        .load  (wb_load),
        .in    (wb_data),
        .src_a (rs1_addr),
        .src_b (f_instr[24:20]),
        .dest  (wb_rd),
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    control_rom u_control_rom (
        .data        (f_instr),
        .alumux1_sel (alumux1_sel),
        .alumux2_sel (alumux2_sel),
        .cmpmux_sel  (cmpmux_sel),
        .alu_op      (ctl_alu_op),
        .alu_alt     (ctl_alu_alt),
        .cmp_op      (ctl_cmp_op),
        .result_sel  (ctl_result_sel),
        .reg_write   (ctl_reg_write),
        .imm_sel     (imm_sel)
    );

    assign alu_a = (alumux1_sel == sel_pc) ? f_pc : reg_a;
    assign alu_b = (alumux2_sel == sel_rs2) ? reg_b : imm;
    assign cmp_b = (cmpmux_sel == cmp_sel_rs2) ? reg_b : i_imm;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            d_valid   <= 1'b0;
            reg_write <= 1'b0;
        end
        else
        begin
            d_valid   <= f_valid;
            reg_write <= ctl_reg_write & f_valid;
        end
        d_pc       <= f_pc;
        d_instr    <= f_instr;
        alu_op     <= ctl_alu_op;
        alu_alt    <= ctl_alu_alt;
        cmp_op     <= ctl_cmp_op;
        result_sel <= ctl_result_sel;
        d_alu_a    <= alu_a;
        d_alu_b    <= alu_b;
        d_cmp_a    <= reg_a;
        d_cmp_b    <= cmp_b;
    end

endmodule

`default_nettype wire

// File: hw/execute.sv
`default_nettype none

`include "rv32i_macros.svh"

module execute
    import rv32i_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    d_valid,
    input  rv32i_word               d_pc,
    input  rv32i_word               d_instr,
    input  alu_ops_t                alu_op,
    input  logic                    alu_alt,
    input  cmp_ops_t                cmp_op,
    input  result_sel_t             result_sel,
    input  logic                    reg_write,
    input  rv32i_word               d_alu_a,
    input  rv32i_word               d_alu_b,
    input  rv32i_word               d_cmp_a,
    input  rv32i_word               d_cmp_b,
    output logic                    retire_valid,
    output rv32i_word               retire_pc,
    output logic [`RV_REG_BITS-1:0] retire_rd,
    output rv32i_word               retire_data,
    output logic                    wb_load,
    output logic [`RV_REG_BITS-1:0] wb_rd,
    output rv32i_word               wb_data
);

    rv32i_word               alu_out;
    rv32i_word               result;
    logic                    lt;
    logic [`RV_REG_BITS-1:0] rd;

    assign rd = d_instr[11:7];

    always_comb
    begin
        case (alu_op)
            alu_add: alu_out = alu_alt ? d_alu_a - d_alu_b : d_alu_a + d_alu_b;
            alu_sll: alu_out = d_alu_a << d_alu_b[4:0];
            alu_xor: alu_out = d_alu_a ^ d_alu_b;
            alu_srl: alu_out = alu_alt ? rv32i_word'($signed(d_alu_a) >>> d_alu_b[4:0])
                                       : d_alu_a >> d_alu_b[4:0];
            alu_or:  alu_out = d_alu_a | d_alu_b;
            default: alu_out = d_alu_a & d_alu_b;
        endcase
    end

    assign lt = (cmp_op == cmp_ltu) ? (d_cmp_a < d_cmp_b)
                                    : ($signed(d_cmp_a) < $signed(d_cmp_b));

    assign result = (result_sel == res_cmp) ? {{(`RV_XLEN-1){1'b0}}, lt} : alu_out;

    // retire register doubles as the writeback port
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            retire_valid <= 1'b0;
            wb_load      <= 1'b0;
        end
        else
        begin
            retire_valid <= d_valid;
            wb_load      <= d_valid && reg_write && rd != '0;
        end
        retire_pc   <= d_pc;
        retire_rd   <= rd;
        retire_data <= result;
    end

    assign wb_rd   = retire_rd;
    assign wb_data = retire_data;

endmodule

`default_nettype wire

// File: hw/rv32i_core.sv
`default_nettype none

`include "rv32i_macros.svh"

module rv32i_core
    import rv32i_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  rv32i_word               instr,
    output logic                    retire_valid,
    output rv32i_word               retire_pc,
    output logic [`RV_REG_BITS-1:0] retire_rd,
    output rv32i_word               retire_data
);

    logic                    f_valid;
    rv32i_word               f_pc;
    rv32i_word               f_instr;
    logic                    d_valid;
    rv32i_word               d_pc;
    rv32i_word               d_instr;
    alu_ops_t                alu_op;
    logic                    alu_alt;
    cmp_ops_t                cmp_op;
    result_sel_t             result_sel;
    logic                    reg_write;
    rv32i_word               d_alu_a;
    rv32i_word               d_alu_b;
    rv32i_word               d_cmp_a;
    rv32i_word               d_cmp_b;
    logic                    wb_load;
    logic [`RV_REG_BITS-1:0] wb_rd;
    rv32i_word               wb_data;

    fetch_stage u_fetch (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .f_valid     (f_valid),
        .f_pc        (f_pc),
        .f_instr     (f_instr)
    );

    instruction_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .f_valid    (f_valid),
        .f_pc       (f_pc),
        .f_instr    (f_instr),
        .wb_load    (wb_load),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .d_valid    (d_valid),
        .d_pc       (d_pc),
        .d_instr    (d_instr),
        .alu_op     (alu_op),
        .alu_alt    (alu_alt),
        .cmp_op     (cmp_op),
        .result_sel (result_sel),
        .reg_write  (reg_write),
        .d_alu_a    (d_alu_a),
        .d_alu_b    (d_alu_b),
        .d_cmp_a    (d_cmp_a),
        .d_cmp_b    (d_cmp_b)
    );

    execute u_execute (
        .clk          (clk),
        .rst          (rst),
        .d_valid      (d_valid),
        .d_pc         (d_pc),
        .d_instr      (d_instr),
        .alu_op       (alu_op),
        .alu_alt      (alu_alt),
        .cmp_op       (cmp_op),
        .result_sel   (result_sel),
        .reg_write    (reg_write),
        .d_alu_a      (d_alu_a),
        .d_alu_b      (d_alu_b),
        .d_cmp_a      (d_cmp_a),
        .d_cmp_b      (d_cmp_b),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .wb_load      (wb_load),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data)
    );

endmodule

`default_nettype wire

// File: tb/rv32i_core_sva.sv
`default_nettype none

`include "rv32i_macros.svh"

module rv32i_core_sva
    import rv32i_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      instr_valid,
    input logic      retire_valid,
    input rv32i_word retire_pc
);

    timeunit 1ns;
    timeprecision 1ps;

    rv32i_word last_pc;
    logic      seen;

    // pc of the previous retirement
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            seen <= 1'b0;
        end
        else if (retire_valid)
        begin
            seen    <= 1'b1;
            last_pc <= retire_pc;
        end
    end

    // capture edge plus two pipeline edges
    a_retire_follows: assert property (@(posedge clk) disable iff (rst)
        instr_valid |-> ##3 retire_valid)
    else $error("retire_valid missing three edges after instr_valid");

    a_no_extra_retire: assert property (@(posedge clk) disable iff (rst)
        !instr_valid |-> ##3 !retire_valid)
    else $error("retire_valid high without an instruction three edges earlier");

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !retire_valid ##1 !retire_valid)
    else $error("retire_valid high during or right after reset");

    a_pc_step: assert property (@(posedge clk) disable iff (rst)
        retire_valid && seen |-> retire_pc == last_pc + `RV_PC_STEP)
    else $error("retire_pc did not advance by one step between retirements");

endmodule

bind rv32i_core rv32i_core_sva u_core_sva (
    .clk          (clk),
    .rst          (rst),
    .instr_valid  (instr_valid),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc)
);

`default_nettype wire

// File: tb/tb_rv32i_core.sv
`default_nettype none

module tb_rv32i_core;

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        check_data;
    } retire_t;

    // instructions issued per test, sizes the watchdog
    localparam int reset_instrs = 1;
    localparam int imm_instrs   = 58;
    localparam int reg_instrs   = 20;
    localparam int upper_instrs = 8;
    localparam int gap_instrs   = 4;
    localparam int unsup_instrs = 3;
    localparam int total_instrs = reset_instrs + imm_instrs + reg_instrs + upper_instrs
                                + gap_instrs + unsup_instrs;
    localparam int drain_limit  = 20;

    // {alt, funct3} for add sub sll slt sltu xor srl sra or and
    localparam logic [3:0] reg_ops [10] = '{4'b0000, 4'b1000, 4'b0001, 4'b0010, 4'b0011,
                                            4'b0100, 4'b0101, 4'b1101, 4'b0110, 4'b0111};

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    logic [31:0] model_regs [32];
    logic [31:0] model_pc;
    logic [15:0] lfsr_state;
    retire_t     expected_q [$];
    retire_t     head;
    string       test_name;
    int          errors;
    int          test_start_errors;
    int          tests_passed;
    int          tests_failed;

    rv32i_core uut (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] itype_word(input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] rtype_word(input logic alt, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] utype_word(input logic [6:0] opc, input logic [4:0] rd,
                                               input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    // RV32I semantics on the model state
    function automatic logic [31:0] model_result(input logic [31:0] iw, input logic [31:0] pc);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [4:0]  sh;
        logic        is_reg;
        is_reg = iw[6:0] == 7'b0110011;
        a = model_regs[iw[19:15]];
        if (is_reg)
            b = model_regs[iw[24:20]];
        else
            b = {{20{iw[31]}}, iw[31:20]};
        sh = b[4:0];
        r = 32'h0;
        if (iw[6:0] == 7'b0110111)
            r = {iw[31:12], 12'h000};
        else if (iw[6:0] == 7'b0010111)
            r = pc + {iw[31:12], 12'h000};
        else if (is_reg || iw[6:0] == 7'b0010011)
        begin
            case (iw[14:12])
                3'd0: r = (is_reg && iw[30]) ? a - b : a + b;
                3'd1: r = a << sh;
                3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: r = (a < b) ? 32'd1 : 32'd0;
                3'd4: r = a ^ b;
                3'd5:
                begin
                    if (iw[30])
                        r = $signed(a) >>> sh;
                    else
                        r = a >> sh;
                end
                3'd6: r = a | b;
                default: r = a & b;
            endcase
        end
        return r;
    endfunction

    task automatic issue(input logic [31:0] iw, input logic check_data);
        retire_t e;
        @(posedge clk);
        #2;
        instr_valid = 1'b1;
        instr = iw;
        e.pc = model_pc;
        e.rd = iw[11:7];
        e.data = model_result(iw, model_pc);
        e.check_data = check_data;
        expected_q.push_back(e);
        // unsupported opcodes leave the register file alone
        if (check_data && iw[11:7] != 5'd0)
            model_regs[iw[11:7]] = e.data;
        model_pc = model_pc + 32'd4;
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #2;
            instr_valid = 1'b0;
            instr = 32'h0000_0013;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_start_errors = errors;
    endtask

    task automatic finish_test();
        int waited;
        waited = 0;
        idle(1);
        while (expected_q.size() != 0 && waited < drain_limit)
        begin
            @(posedge clk);
            waited++;
        end
        if (expected_q.size() != 0)
        begin
            $display("%s: %0d instructions never retired", test_name, expected_q.size());
            errors++;
            expected_q.delete();
        end
        if (errors == test_start_errors)
        begin
            $display("test %s: ok", test_name);
            tests_passed++;
        end
        else
        begin
            $display("test %s: failed with %0d errors", test_name, errors - test_start_errors);
            tests_failed++;
        end
    endtask

    // compare each retirement with the oldest outstanding instruction
    always @(negedge clk)
    begin
        if (retire_valid === 1'b1)
        begin
            if (expected_q.size() == 0)
            begin
                $display("%s: retirement at pc %h with nothing outstanding", test_name,
                         retire_pc);
                errors++;
            end
            else
            begin
                head = expected_q.pop_front();
                assert (retire_pc == head.pc)
                else
                begin
                    $display("Mismatch %s pc: expected %h actual %h", test_name, head.pc,
                             retire_pc);
                    errors++;
                end
                assert (retire_rd == head.rd)
                else
                begin
                    $display("Mismatch %s rd: expected %0d actual %0d", test_name, head.rd,
                             retire_rd);
                    errors++;
                end
                assert (!head.check_data || retire_data == head.data)
                else
                begin
                    $display("Mismatch %s data: expected %h actual %h", test_name, head.data,
                             retire_data);
                    errors++;
                end
            end
        end
    end

    initial
    begin
        repeat (total_instrs * 4 + 100) @(posedge clk);
        $display("watchdog expired, pipeline stopped retiring instructions");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [4:0]  prev;
        int          k;
        int          waited;

        rst = 1'b1;
        instr_valid = 1'b0;
        instr = 32'h0000_0013;
        model_pc = 32'h0;
        lfsr_state = 16'd15;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_name = "reset";
        for (int i = 0; i < 32; i++)
            model_regs[i] = 32'h0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        start_test("reset");
        idle(4);
        issue(itype_word(3'd0, 5'd1, 5'd0, 12'h123), 1'b1);
        idle(1);
        waited = 0;
        while (retire_valid !== 1'b1 && waited < drain_limit)
        begin
            @(negedge clk);
            waited++;
        end
        if (retire_valid !== 1'b1)
        begin
            $display("reset: first instruction never retired");
            errors++;
        end
        else
        begin
            assert (retire_pc == 32'h0)
            else
            begin
                $display("Mismatch reset first pc: expected %h actual %h", 32'h0, retire_pc);
                errors++;
            end
        end
        finish_test();

        start_test("imm_alu");
        for (int r = 1; r < 32; r++)
        begin
            imm12 = 12'(rand_bits(12));
            issue(itype_word(3'd0, r[4:0], 5'd0, imm12), 1'b1);
        end
        idle(2);
        // sources x1..x15, destinations x16..x31
        for (int i = 0; i < 27; i++)
        begin
            k = i % 9;
            rs1 = 5'(1 + i % 15);
            rd = 5'(16 + i % 16);
            imm12 = 12'(rand_bits(12));
            if (k == 1 || k == 5)
                imm12 = {7'b0000000, imm12[4:0]};
            if (k == 8)
                issue(itype_word(3'd5, rd, rs1, {7'b0100000, imm12[4:0]}), 1'b1);
            else
                issue(itype_word(3'(k), rd, rs1, imm12), 1'b1);
        end
        finish_test();

        start_test("reg_alu");
        prev = 5'd16;
        for (int i = 0; i < 20; i++)
        begin
            k = i % 10;
            rs2 = 5'(rand_bits(5));
            rd = 5'(rand_bits(5));
            issue(rtype_word(reg_ops[k][3], reg_ops[k][2:0], rd, prev, rs2), 1'b1);
            // consumer two cycles behind its producer
            idle(1);
            prev = rd;
        end
        finish_test();

        start_test("upper_imm");
        for (int i = 0; i < 4; i++)
        begin
            issue(utype_word(7'b0110111, 5'(8 + i), 20'(rand_bits(20))), 1'b1);
            issue(utype_word(7'b0010111, 5'(12 + i), 20'(rand_bits(20))), 1'b1);
        end
        finish_test();

        start_test("x0_and_gaps");
        issue(itype_word(3'd0, 5'd0, 5'd3, 12'h5a5), 1'b1);
        issue(rtype_word(1'b0, 3'd6, 5'd0, 5'd1, 5'd2), 1'b1);
        idle(3);
        issue(itype_word(3'd0, 5'd20, 5'd0, 12'h000), 1'b1);
        idle(5);
        issue(itype_word(3'd4, 5'd21, 5'd0, 12'h0ff), 1'b1);
        finish_test();

        start_test("unsupported_op");
        issue(itype_word(3'd0, 5'd5, 5'd0, 12'h155), 1'b1);
        idle(1);
        // lw x5, 0(x1)
        issue({12'h000, 5'd1, 3'b010, 5'd5, 7'b0000011}, 1'b0);
        idle(1);
        issue(itype_word(3'd0, 5'd6, 5'd5, 12'h000), 1'b1);
        finish_test();

        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+hw
hw/rv32i_pkg.sv
hw/fetch_stage.sv
hw/regfile.sv
hw/control_rom.sv
hw/instruction_decode.sv
hw/execute.sv
hw/rv32i_core.sv
tb/rv32i_core_sva.sv
tb/tb_rv32i_core.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the rv32i_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_rv32i_core -f filelist.f

./obj_dir/Vtb_rv32i_core > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi

if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi

exit 0
